//--- Makefile
# Verilator build and run for the FIX parser testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module fix_parser_tb -Mdir obj_dir -o fix_parser_sim

# error limit raised so every assertion failure reaches the log
run: compile
	./obj_dir/fix_parser_sim +verilator+error+limit+100 > sim.log 2>&1; \
		status=$$?; cat sim.log; exit $$status
	@if grep -q "Finished with errors" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- bench/fix_parser_props.sv
//**************************************************
// output protocol checks, bound into fix_parser_top
// fail_count is read by the testbench at the end
//**************************************************
`timescale 1ns/1ps
`include "fix_params.svh"

module fix_parser_props import fix_pkg::*; (
	input logic     clk,
	input logic     rst,
	input logic     field_valid_i,
	input logic     start_of_header_i,
	input logic     end_of_body_i,
	input logic     msg_done_i,
	input fix_len_t value_len_i
);

	int fail_count = 0;

	// header and trailer flags only ride on a field
	flag_with_field: assert property (@(posedge clk) disable iff (rst)
		(start_of_header_i || end_of_body_i) |-> field_valid_i)
		else begin
			fail_count = fail_count + 1;
			$error("header or trailer flag without field_valid_o");
		end

	flags_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(start_of_header_i && end_of_body_i))
		else begin
			fail_count = fail_count + 1;
			$error("start_of_header_o and end_of_body_o high together");
		end

	done_after_trailer: assert property (@(posedge clk) disable iff (rst)
		msg_done_i |-> $past(end_of_body_i))
		else begin
			fail_count = fail_count + 1;
			$error("msg_done_o without end_of_body_o one cycle earlier");
		end

	len_in_range: assert property (@(posedge clk) disable iff (rst)
		value_len_i <= fix_len_t'(`FIX_VALUE_BYTES))
		else begin
			fail_count = fail_count + 1;
			$error("value_len_o above the stored maximum");
		end

endmodule

bind fix_parser_top fix_parser_props props0 (
	.clk               (clk),
	.rst               (rst),
	.field_valid_i     (field_valid_o),
	.start_of_header_i (start_of_header_o),
	.end_of_body_i     (end_of_body_o),
	.msg_done_i        (msg_done_o),
	.value_len_i       (value_len_o)
);

//--- bench/fix_parser_tb.sv
//**************************************************
// directed tests, second pass with random idle gaps
// latency counted in falling edges from SOH on the input
//**************************************************
`timescale 1ns/1ps
`include "fix_params.svh"

module fix_parser_tb import fix_pkg::*; ();

	// bytes over both passes, gaps at most double it
	localparam int bytes_sent = 280;
	localparam int cycle_limit = 2 * bytes_sent + 300;

	logic        clk;
	logic        rst;
	logic [7:0]  byte_i;
	logic        byte_valid_i;
	logic        field_valid_o;
	fix_tag_t    tag_o;
	fix_value_t  value_o;
	fix_len_t    value_len_o;
	logic        overflow_o;
	logic        start_of_header_o;
	logic        end_of_body_o;
	logic        msg_done_o;
	logic        checksum_ok_o;
	logic [7:0]  checksum_calc_o;
	logic [7:0]  checksum_recv_o;

	int          cycle;
	int          errors;
	int          eob_cycle;
	logic        use_gaps;
	logic [7:0]  msg_sum;
	int          soh_q[$];
	fix_tag_t    tag_q[$];
	fix_value_t  value_q[$];
	fix_len_t    len_q[$];
	logic [2:0]  flag_q[$];
	logic [16:0] msg_q[$];

	fix_parser_top dut0 (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check_val(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// right-aligned, last character in the low byte
	function automatic fix_tag_t tag_word(input string s);
		fix_tag_t w;
		w = '0;
		for (int i = 0; i < s.len(); i++) begin
			w = (w << 8) | fix_tag_t'(s[i]);
		end
		return w;
	endfunction

	// first character in the low byte, excess dropped
	function automatic fix_value_t value_word(input string s);
		fix_value_t w;
		w = '0;
		for (int i = 0; i < s.len() && i < `FIX_VALUE_BYTES; i++) begin
			w[8*i +: 8] = s[i];
		end
		return w;
	endfunction

	task automatic put_byte(input logic [7:0] b);
		int idle;
		idle = use_gaps ? int'($urandom % 2) : 0;
		repeat (idle) begin
			@(posedge clk);
			byte_valid_i <= 1'b0;
		end
		@(posedge clk);
		byte_i <= b;
		byte_valid_i <= 1'b1;
		msg_sum = msg_sum + b;
	endtask

	task automatic send_field(input string tag, input string value);
		for (int i = 0; i < tag.len(); i++) begin
			put_byte(tag[i]);
		end
		put_byte(`FIX_EQ);
		for (int i = 0; i < value.len(); i++) begin
			put_byte(value[i]);
		end
		put_byte(`FIX_SOH);
	endtask

	task automatic end_input();
		@(posedge clk);
		byte_valid_i <= 1'b0;
	endtask

	// runs on every falling edge, outputs are stable there
	task automatic collect_outputs();
		if (byte_valid_i && byte_i == `FIX_SOH) begin
			soh_q.push_back(cycle);
		end
		if (field_valid_o) begin
			assert (soh_q.size() != 0) else begin
				errors++;
				$display("field_valid_o pulsed with no SOH sent before it");
			end
			if (soh_q.size() != 0) begin
				// two registers, the first one at the sampling edge
				check_val("field_valid_o latency", cycle - soh_q.pop_front(), 2);
			end
			tag_q.push_back(tag_o);
			value_q.push_back(value_o);
			len_q.push_back(value_len_o);
			flag_q.push_back({overflow_o, start_of_header_o, end_of_body_o});
			if (end_of_body_o) begin
				eob_cycle = cycle;
			end
		end
		if (msg_done_o) begin
			check_val("msg_done_o latency", cycle - eob_cycle, 1);
			msg_q.push_back({checksum_ok_o, checksum_calc_o, checksum_recv_o});
		end
	endtask

	task automatic check_field(input string tag, input string value, input logic soh,
			input logic eob);
		logic [2:0] flags;
		int         kept;
		kept = (value.len() > `FIX_VALUE_BYTES) ? `FIX_VALUE_BYTES : value.len();
		while (flag_q.size() == 0) begin
			@(posedge clk);
		end
		flags = flag_q.pop_front();
		check_val("tag_o", tag_q.pop_front(), tag_word(tag));
		check_val("value_o", value_q.pop_front(), value_word(value));
		check_val("value_len_o", len_q.pop_front(), kept);
		check_val("overflow_o", flags[2], value.len() > `FIX_VALUE_BYTES);
		check_val("start_of_header_o", flags[1], soh);
		check_val("end_of_body_o", flags[0], eob);
	endtask

	task automatic check_msg(input logic ok, input logic [7:0] calc, input logic [7:0] recv);
		logic [16:0] m;
		while (msg_q.size() == 0) begin
			@(posedge clk);
		end
		m = msg_q.pop_front();
		check_val("checksum_ok_o", m[16], ok);
		check_val("checksum_calc_o", m[15:8], calc);
		check_val("checksum_recv_o", m[7:0], recv);
	endtask

	task automatic test_idle();
		repeat (10) begin
			@(negedge clk);
			check_val("lex_strobe", dut0.lex_strobe, 1'b0);
			check_val("field_valid_o", field_valid_o, 1'b0);
			check_val("start_of_header_o", start_of_header_o, 1'b0);
			check_val("end_of_body_o", end_of_body_o, 1'b0);
			check_val("msg_done_o", msg_done_o, 1'b0);
			check_val("checksum_ok_o", checksum_ok_o, 1'b0);
		end
	endtask

	task automatic test_message(input logic bad);
		logic [7:0] body_sum;
		logic [7:0] sent;
		string      digits;
		msg_sum = 8'h00;
		send_field("8", "FIX.4.4");
		send_field("35", "D");
		send_field("49", "SENDER");
		send_field("56", "TARGET");
		// everything from tag 8 up to the SOH before tag 10
		body_sum = msg_sum;
		sent = bad ? body_sum + 8'd1 : body_sum;
		digits = $sformatf("%c%c%c", 8'h30 + sent / 100, 8'h30 + (sent / 10) % 10,
			8'h30 + sent % 10);
		send_field("10", digits);
		end_input();
		check_field("8", "FIX.4.4", 1'b1, 1'b0);
		check_field("35", "D", 1'b0, 1'b0);
		check_field("49", "SENDER", 1'b0, 1'b0);
		check_field("56", "TARGET", 1'b0, 1'b0);
		check_field("10", digits, 1'b0, 1'b1);
		check_msg(!bad, body_sum, sent);
	endtask

	task automatic test_long_value();
		string long_value;
		long_value = "ABCDEFGHIJ=LMNOPQRSTU=WXYZ0123456789abcd";
		send_field("58", long_value);
		send_field("58", "A=B");
		end_input();
		check_field("58", long_value, 1'b0, 1'b0);
		check_field("58", "A=B", 1'b0, 1'b0);
	endtask

	always @(negedge clk) begin
		cycle = cycle + 1;
		collect_outputs();
		if (cycle >= cycle_limit) begin
			$display("timeout, run still busy after %0d cycles", cycle);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		int pass;
		errors = 0;
		cycle = 0;
		eob_cycle = 0;
		use_gaps = 1'b0;
		msg_sum = 8'h00;
		rst = 1'b1;
		byte_i = 8'h00;
		byte_valid_i = 1'b0;
		void'($urandom(32'he1b7));
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		test_idle();
		for (pass = 0; pass < 2; pass++) begin
			use_gaps = (pass == 1);
			send_field("35", "D");
			end_input();
			check_field("35", "D", 1'b0, 1'b0);
			test_message(1'b0);
			test_message(1'b1);
			test_long_value();
		end
		repeat (10) @(posedge clk);
		assert (soh_q.size() == 0 && flag_q.size() == 0 && msg_q.size() == 0) else begin
			errors++;
			$display("unexpected fields or messages left after the last test");
		end
		$display("errors: %0d in checks, %0d in assertions", errors,
			dut0.props0.fail_count);
		if (errors == 0 && dut0.props0.fail_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+verilog
verilog/fix_pkg.sv
verilog/fix_lexer.sv
verilog/fix_field_extractor.sv
verilog/fix_checksum.sv
verilog/fix_parser_top.sv
bench/fix_parser_props.sv
bench/fix_parser_tb.sv

//--- verilog/fix_checksum.sv
//**************************************************
// sums bytes from the tag 8 field up to the SOH before tag 10
// the trailer must carry exactly three decimal digits
//**************************************************
`timescale 1ns/1ps
`include "fix_params.svh"

module fix_checksum import fix_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] lex_byte_i,
	input  logic       lex_strobe_i,
	input  logic       field_valid_i,
	input  logic       start_of_header_i,
	input  logic       end_of_body_i,
	input  fix_value_t value_i,
	input  fix_len_t   value_len_i,
	output logic       msg_done_o,
	output logic       checksum_ok_o,
	output logic [7:0] checksum_calc_o,
	output logic [7:0] checksum_recv_o
);

	// all sums wrap at 256
	logic [7:0] field_sum;
	logic [7:0] pending_sum;
	logic [7:0] total;

	logic [7:0]  dig_hi;
	logic [7:0]  dig_mid;
	logic [7:0]  dig_lo;
	logic        digits_ok;
	logic [10:0] recv_num;

	// sum of the current field, handed over at SOH
	always_ff @(posedge clk) begin
		if (rst) begin
			field_sum <= '0;
			pending_sum <= '0;
		end else if (lex_strobe_i) begin
			if (lex_byte_i == `FIX_SOH) begin
				pending_sum <= field_sum + lex_byte_i;
				field_sum <= '0;
			end else begin
				field_sum <= field_sum + lex_byte_i;
			end
		end
	end

	// tag 8 restarts, tag 10 itself is left out
	always_ff @(posedge clk) begin
		if (rst) begin
			total <= '0;
		end else if (field_valid_i) begin
			if (start_of_header_i) begin
				total <= pending_sum;
			end else if (!end_of_body_i) begin
				total <= total + pending_sum;
			end
		end
	end

	// ASCII digits to a number; below '0' wraps high and fails the check
	assign dig_hi = value_i[7:0] - 8'h30;
	assign dig_mid = value_i[15:8] - 8'h30;
	assign dig_lo = value_i[23:16] - 8'h30;
	assign digits_ok = (value_len_i == 6'd3) && (dig_hi < 8'd10) &&
		(dig_mid < 8'd10) && (dig_lo < 8'd10);
	assign recv_num = 11'(dig_hi[3:0]) * 11'd100 + 11'(dig_mid[3:0]) * 11'd10 +
		11'(dig_lo[3:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			msg_done_o <= 1'b0;
			checksum_ok_o <= 1'b0;
		end else begin
			msg_done_o <= field_valid_i && end_of_body_i;
			if (field_valid_i && end_of_body_i) begin
				checksum_ok_o <= digits_ok && (recv_num == {3'b000, total});
			end
		end
	end

	always_ff @(posedge clk) begin
		if (field_valid_i && end_of_body_i) begin
			checksum_calc_o <= total;
			checksum_recv_o <= recv_num[7:0];
		end
	end

endmodule

//--- verilog/fix_field_extractor.sv
//**************************************************
// builds tag and value of one field at a time
// only the most recent field is held on the outputs
// values beyond FIX_VALUE_BYTES are dropped and flagged
//**************************************************
`timescale 1ns/1ps
`include "fix_params.svh"

module fix_field_extractor import fix_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  logic [7:0]     lex_byte_i,
	input  fix_byte_kind_e lex_kind_i,
	input  logic           lex_strobe_i,
	output logic           field_valid_o,
	output fix_tag_t       tag_o,
	output fix_value_t     value_o,
	output fix_len_t       value_len_o,
	output logic           overflow_o,
	output logic           start_of_header_o,
	output logic           end_of_body_o
);

	// "8" and "10" in ASCII, right-aligned
	localparam fix_tag_t tag_begin = fix_tag_t'(8'h38);
	localparam fix_tag_t tag_check = fix_tag_t'(16'h3130);

	localparam fix_len_t value_max = fix_len_t'(`FIX_VALUE_BYTES);

	// working copy of the field in progress
	fix_tag_t   work_tag;
	fix_value_t work_value;
	fix_len_t   work_len;
	logic       work_ovf;

	logic field_end;
	logic value_full;

	assign field_end = lex_strobe_i && (lex_kind_i == kind_end);
	assign value_full = (work_len == value_max);

	// gather characters until SOH
	always_ff @(posedge clk) begin
		if (rst) begin
			work_tag <= '0;
			work_value <= '0;
			work_len <= '0;
			work_ovf <= 1'b0;
		end else if (lex_strobe_i) begin
			case (lex_kind_i)
				kind_tag: begin
					// shift left so the last character lands in the low byte
					work_tag <= {work_tag[`FIX_TAG_BYTES*8-9:0], lex_byte_i};
				end
				kind_value: begin
					if (value_full) begin
						work_ovf <= 1'b1;
					end else begin
						work_value[8*work_len[4:0] +: 8] <= lex_byte_i;
						work_len <= work_len + 6'd1;
					end
				end
				kind_end: begin
					// fresh state for the next field
					work_tag <= '0;
					work_value <= '0;
					work_len <= '0;
					work_ovf <= 1'b0;
				end
				default: begin
					// separator only changes the lexer mode
					work_len <= work_len;
				end
			endcase
		end
	end

	// strobes and flags
	always_ff @(posedge clk) begin
		if (rst) begin
			field_valid_o <= 1'b0;
			start_of_header_o <= 1'b0;
			end_of_body_o <= 1'b0;
			overflow_o <= 1'b0;
			value_len_o <= '0;
		end else begin
			field_valid_o <= field_end;
			start_of_header_o <= field_end && (work_tag == tag_begin);
			end_of_body_o <= field_end && (work_tag == tag_check);
			if (field_end) begin
				overflow_o <= work_ovf;
				value_len_o <= work_len;
			end
		end
	end

	// field contents, held until the next field end
	always_ff @(posedge clk) begin
		if (field_end) begin
			tag_o <= work_tag;
			value_o <= work_value;
		end
	end

endmodule

//--- verilog/fix_lexer.sv
//**************************************************
// one byte per cycle at most, no back-pressure
// output is the input byte and its class, one cycle later
//**************************************************
`timescale 1ns/1ps
`include "fix_params.svh"

module fix_lexer import fix_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  logic [7:0]     byte_i,
	input  logic           byte_valid_i,
	output logic [7:0]     lex_byte_o,
	output fix_byte_kind_e lex_kind_o,
	output logic           lex_strobe_o
);

	// low in tag mode, high once the separator has been seen
	logic value_mode;

	fix_byte_kind_e kind;
	logic           next_value_mode;

	always_comb begin
		kind = kind_tag;
		next_value_mode = value_mode;
		if (byte_i == `FIX_SOH) begin
			// SOH closes the field from either mode
			kind = kind_end;
			next_value_mode = 1'b0;
		end else if (!value_mode) begin
			if (byte_i == `FIX_EQ) begin
				kind = kind_sep;
				next_value_mode = 1'b1;
			end else begin
				kind = kind_tag;
			end
		end else begin
			// a later '=' is just part of the value
			kind = kind_value;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			value_mode <= 1'b0;
		end else if (byte_valid_i) begin
			value_mode <= next_value_mode;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lex_strobe_o <= 1'b0;
			lex_kind_o <= kind_tag;
		end else begin
			lex_strobe_o <= byte_valid_i;
			if (byte_valid_i) begin
				lex_kind_o <= kind;
			end
		end
	end

	// byte itself carries no control meaning past this point
	always_ff @(posedge clk) begin
		if (byte_valid_i) begin
			lex_byte_o <= byte_i;
		end
	end

endmodule

//--- verilog/fix_params.svh
//**************************************************
// field widths and delimiter codes for the FIX parser
// tags longer than FIX_TAG_BYTES keep only their last characters
//**************************************************
`ifndef FIX_PARAMS_SVH
`define FIX_PARAMS_SVH

// longest tag held, in characters
`define FIX_TAG_BYTES 4

// value characters kept per field, the rest only flag overflow
`define FIX_VALUE_BYTES 32

// SOH ends every field
`define FIX_SOH 8'h01

// '=' splits tag from value
`define FIX_EQ 8'h3D

`endif

//--- verilog/fix_parser_top.sv
//**************************************************
// FIX parser, lexer -> field extractor -> checksum
// field_valid_o two cycles after SOH, msg_done_o one more
//**************************************************
`timescale 1ns/1ps

module fix_parser_top import fix_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] byte_i,
	input  logic       byte_valid_i,
	output logic       field_valid_o,
	output fix_tag_t   tag_o,
	output fix_value_t value_o,
	output fix_len_t   value_len_o,
	output logic       overflow_o,
	output logic       start_of_header_o,
	output logic       end_of_body_o,
	output logic       msg_done_o,
	output logic       checksum_ok_o,
	output logic [7:0] checksum_calc_o,
	output logic [7:0] checksum_recv_o
);

	logic [7:0]     lex_byte;
	fix_byte_kind_e lex_kind;
	logic           lex_strobe;

	fix_lexer lexer0 (
		.clk          (clk),
		.rst          (rst),
		.byte_i       (byte_i),
		.byte_valid_i (byte_valid_i),
		.lex_byte_o   (lex_byte),
		.lex_kind_o   (lex_kind),
		.lex_strobe_o (lex_strobe)
	);

	fix_field_extractor extract0 (
		.clk               (clk),
		.rst               (rst),
		.lex_byte_i        (lex_byte),
		.lex_kind_i        (lex_kind),
		.lex_strobe_i      (lex_strobe),
		.field_valid_o     (field_valid_o),
		.tag_o             (tag_o),
		.value_o           (value_o),
		.value_len_o       (value_len_o),
		.overflow_o        (overflow_o),
		.start_of_header_o (start_of_header_o),
		.end_of_body_o     (end_of_body_o)
	);

	// sees raw bytes for the sum and the extractor result for the trailer
	fix_checksum check0 (
		.clk               (clk),
		.rst               (rst),
		.lex_byte_i        (lex_byte),
		.lex_strobe_i      (lex_strobe),
		.field_valid_i     (field_valid_o),
		.start_of_header_i (start_of_header_o),
		.end_of_body_i     (end_of_body_o),
		.value_i           (value_o),
		.value_len_i       (value_len_o),
		.msg_done_o        (msg_done_o),
		.checksum_ok_o     (checksum_ok_o),
		.checksum_calc_o   (checksum_calc_o),
		.checksum_recv_o   (checksum_recv_o)
	);

endmodule

//--- verilog/fix_pkg.sv
//**************************************************
// shared types for the FIX parser
// widths follow fix_params.svh
//**************************************************
package fix_pkg;

`include "fix_params.svh"

	// right-aligned, last tag character in the low byte
	typedef logic [`FIX_TAG_BYTES*8-1:0] fix_tag_t;

	// first value character in the low byte
	typedef logic [`FIX_VALUE_BYTES*8-1:0] fix_value_t;

	// 0 to FIX_VALUE_BYTES characters stored
	typedef logic [5:0] fix_len_t;

	// lexer classification of one byte
	typedef enum logic [1:0] {
		kind_tag   = 2'd0,
		kind_sep   = 2'd1,
		kind_value = 2'd2,
		kind_end   = 2'd3
	} fix_byte_kind_e;

endpackage
